//--- bench/inv_mix_stim.txt
// Each record: four input column words, then four expected output words
// A word is one column with row 0 in bits 7:0
bca14d8e 9d58dc9f d6d7d5d5 f8bd7e4d
455313db 5c220af2 d5d4d4d4 4c31262d

01010101 c6c6c6c6 00000001 00000100
01010101 c6c6c6c6 0b0d090e 0d090e0b

00000000 ffffffff 00000002 bca14d8f
00000000 ffffffff 161a121c 4e5e1ad5

00010000 01000000 c6c6c6c7 00000101
090e0b0d 0e0b0d09 cdcbcfc8 06040705

f8bd7e4d d6d7d5d5 9d58dc9f bca14d8e
4c31262d d5d4d4d4 5c220af2 455313db

//--- tb.f
src/gf_pkg.sv
src/axil_pkg.sv
src/gf_mul_const.sv
src/inv_mix_column.sv
src/inv_mix_core.sv
src/axil_regs.sv
src/aes_inv_mix_axil.sv
bench/tb_aes_inv_mix.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_aes_inv_mix
FILELIST  := tb.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/tb_aes_inv_mix.sv
`timescale 1ns/1ps
/* Testbench for the AXI4-Lite inverse MixColumns engine
   Replays stimulus records and checks bus responses */
module tb_aes_inv_mix import gf_pkg::*, axil_pkg::*; ();

        localparam int NUM_COLS = 4;
        localparam int NUM_REC = 5;
        localparam int TIMEOUT = 100;

        logic clk;
        logic rst;
        axil_addr_t awaddr;
        logic awvalid;
        logic awready;
        axil_data_t wdata;
        logic wvalid;
        logic wready;
        axil_resp_t bresp;
        logic bvalid;
        logic bready;
        axil_addr_t araddr;
        logic arvalid;
        logic arready;
        axil_data_t rdata;
        axil_resp_t rresp;
        logic rvalid;
        logic rready;

        column_t stim_mem [NUM_REC*8];  // 4 inputs then 4 expected per record
        logic [31:0] rnd_state;
        logic no_delay;
        int errors;
        int checks;

        aes_inv_mix_axil #(.NUM_COLS(NUM_COLS)) uut (.*);

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        function automatic logic [31:0] xorshift(input logic [31:0] s);
                logic [31:0] x;
                x = s;
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                return x;
        endfunction

        function automatic axil_addr_t din_addr(input int c);
                return 8'(ADDR_DIN_BASE + 4 * c);
        endfunction

        function automatic axil_addr_t dout_addr(input int c);
                return 8'(ADDR_DOUT_BASE + 4 * c);
        endfunction

        task automatic pick_delay(output int d);
                rnd_state = xorshift(rnd_state);
                d = no_delay ? 0 : int'(rnd_state[1:0]);       // 0 to 3 cycles
        endtask

        task automatic check_word(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
                end
        endtask

        task automatic give_up(input string what);
                $display("Timed out waiting for %s", what);
                $display("Checks: %0d, errors: %0d", checks, errors);
                $display("ERRORS FOUND");
                $finish;
        endtask

        task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                                  output axil_resp_t resp);
                int n;
                int d;
                @(posedge clk);
                awaddr <= addr;
                wdata <= data;
                awvalid <= 1'b1;
                wvalid <= 1'b1;
                n = 0;
                do begin
                        @(posedge clk);
                        n++;
                end while (!(awready && wready) && n < TIMEOUT);
                if (!(awready && wready))
                        give_up("awready and wready");
                awvalid <= 1'b0;
                wvalid <= 1'b0;
                pick_delay(d);
                repeat (d) @(posedge clk);
                bready <= 1'b1;
                n = 0;
                do begin
                        @(posedge clk);
                        n++;
                end while (!bvalid && n < TIMEOUT);
                if (!bvalid)
                        give_up("bvalid");
                resp = bresp;
                bready <= 1'b0;
                @(posedge clk);
                if (bvalid) begin       // Response must drop after one transfer
                        errors++;
                        $display("Write response at 0x%02h was delivered twice", addr);
                end
        endtask

        task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                                 output axil_resp_t resp);
                int n;
                int d;
                @(posedge clk);
                araddr <= addr;
                arvalid <= 1'b1;
                n = 0;
                do begin
                        @(posedge clk);
                        n++;
                end while (!arready && n < TIMEOUT);
                if (!arready)
                        give_up("arready");
                arvalid <= 1'b0;
                pick_delay(d);
                repeat (d) @(posedge clk);
                rready <= 1'b1;
                n = 0;
                do begin
                        @(posedge clk);
                        n++;
                end while (!rvalid && n < TIMEOUT);
                if (!rvalid)
                        give_up("rvalid");
                data = rdata;
                resp = rresp;
                rready <= 1'b0;
                @(posedge clk);
                if (rvalid) begin
                        errors++;
                        $display("Read data at 0x%02h was delivered twice", addr);
                end
        endtask

        task automatic read_expect(input axil_addr_t addr, input axil_data_t exp,
                                   input axil_resp_t exp_resp);
                axil_data_t data;
                axil_resp_t resp;
                axil_read(addr, data, resp);
                check_word($sformatf("rdata at 0x%02h", addr), data, exp);
                check_word($sformatf("rresp at 0x%02h", addr), 32'(resp), 32'(exp_resp));
        endtask

        task automatic write_expect(input axil_addr_t addr, input axil_data_t data,
                                    input axil_resp_t exp_resp);
                axil_resp_t resp;
                axil_write(addr, data, resp);
                check_word($sformatf("bresp at 0x%02h", addr), 32'(resp), 32'(exp_resp));
        endtask

        task automatic wait_done();
                axil_data_t st;
                axil_resp_t resp;
                int n;
                n = 0;
                do begin
                        axil_read(ADDR_STATUS, st, resp);
                        n++;
                end while (!st[1] && n < TIMEOUT);
                if (!st[1])
                        give_up("done in STATUS");
                check_word("status busy", 32'(st[0]), 32'd0);
        endtask

        task automatic load_record(input int r);
                for (int c = 0; c < NUM_COLS; c++)
                        write_expect(din_addr(c), stim_mem[r*8 + c], RESP_OKAY);
        endtask

        task automatic check_record(input int r);
                for (int c = 0; c < NUM_COLS; c++)
                        read_expect(dout_addr(c), stim_mem[r*8 + 4 + c], RESP_OKAY);
        endtask

        initial begin
                axil_data_t pat [NUM_COLS];
                rst = 1'b1;
                awaddr = '0;
                awvalid = 1'b0;
                wdata = '0;
                wvalid = 1'b0;
                bready = 1'b0;
                araddr = '0;
                arvalid = 1'b0;
                rready = 1'b0;
                rnd_state = 32'd25;
                no_delay = 1'b0;
                errors = 0;
                checks = 0;
                $readmemh("bench/inv_mix_stim.txt", stim_mem);
                repeat (2) @(posedge clk);
                rst <= 1'b0;

                read_expect(ADDR_STATUS, '0, RESP_OKAY);
                for (int c = 0; c < NUM_COLS; c++)
                        read_expect(dout_addr(c), '0, RESP_OKAY);

                for (int c = 0; c < NUM_COLS; c++) begin
                        rnd_state = xorshift(rnd_state);
                        pat[c] = rnd_state;
                        write_expect(din_addr(c), pat[c], RESP_OKAY);
                end
                for (int c = 0; c < NUM_COLS; c++)
                        read_expect(din_addr(c), pat[c], RESP_OKAY);

                for (int r = 0; r < NUM_REC; r++) begin
                        load_record(r);
                        write_expect(ADDR_CTRL, 32'd1, RESP_OKAY);
                        wait_done();
                        check_record(r);
                end

                // Back-to-back writes so the second start lands mid-run
                no_delay = 1'b1;
                load_record(0);
                write_expect(ADDR_CTRL, 32'd1, RESP_OKAY);
                write_expect(ADDR_CTRL, 32'd1, RESP_OKAY);
                wait_done();
                check_record(0);

                // Last column first, so its new word lands before the run mixes it
                load_record(1);
                write_expect(ADDR_CTRL, 32'd1, RESP_OKAY);
                for (int c = NUM_COLS - 1; c >= 0; c--)
                        write_expect(din_addr(c), ~stim_mem[8 + c], RESP_OKAY);
                wait_done();
                no_delay = 1'b0;
                check_record(1);

                read_expect(8'h20, '0, RESP_SLVERR);
                read_expect(din_addr(NUM_COLS), '0, RESP_SLVERR);
                read_expect(dout_addr(NUM_COLS), '0, RESP_SLVERR);
                read_expect(dout_addr(15), '0, RESP_SLVERR);
                write_expect(ADDR_STATUS, 32'h3, RESP_SLVERR);
                write_expect(dout_addr(0), 32'hdeadbeef, RESP_SLVERR);
                write_expect(din_addr(NUM_COLS), 32'h1234, RESP_SLVERR);
                read_expect(ADDR_CTRL, '0, RESP_OKAY);
                read_expect(ADDR_STATUS, 32'h2, RESP_OKAY);
                check_record(1);
                for (int c = 0; c < NUM_COLS; c++)
                        read_expect(din_addr(c), ~stim_mem[8 + c], RESP_OKAY);

                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("NO ERRORS");
                else
                        $display("ERRORS FOUND");
                $finish;
        end

endmodule

//--- src/aes_inv_mix_axil.sv
`timescale 1ns/1ps
/* AES inverse MixColumns engine with an AXI4-Lite register port */
module aes_inv_mix_axil import gf_pkg::*, axil_pkg::*; #(
        parameter int NUM_COLS = 4
) (
        input  logic       clk,
        input  logic       rst,
        input  axil_addr_t awaddr,
        input  logic       awvalid,
        output logic       awready,
        input  axil_data_t wdata,
        input  logic       wvalid,
        output logic       wready,
        output axil_resp_t bresp,
        output logic       bvalid,
        input  logic       bready,
        input  axil_addr_t araddr,
        input  logic       arvalid,
        output logic       arready,
        output axil_data_t rdata,
        output axil_resp_t rresp,
        output logic       rvalid,
        input  logic       rready
);

        logic start;
        logic busy;
        logic done;
        column_t [NUM_COLS-1:0] din_block;
        column_t [NUM_COLS-1:0] dout_block;

        axil_regs #(.NUM_COLS(NUM_COLS)) u_regs (
                .clk(clk),
                .rst(rst),
                .awaddr(awaddr),
                .awvalid(awvalid),
                .awready(awready),
                .wdata(wdata),
                .wvalid(wvalid),
                .wready(wready),
                .bresp(bresp),
                .bvalid(bvalid),
                .bready(bready),
                .araddr(araddr),
                .arvalid(arvalid),
                .arready(arready),
                .rdata(rdata),
                .rresp(rresp),
                .rvalid(rvalid),
                .rready(rready),
                .start(start),
                .din_block(din_block),
                .busy(busy),
                .done(done),
                .dout_block(dout_block)
        );

        inv_mix_core #(.NUM_COLS(NUM_COLS)) u_core (
                .clk(clk),
                .rst(rst),
                .start(start),
                .din_block(din_block),
                .busy(busy),
                .done(done),
                .dout_block(dout_block)
        );

endmodule

//--- src/axil_regs.sv
`timescale 1ns/1ps
/* AXI4-Lite register slave
   Holds the input columns and exposes control, status and results */
module axil_regs import axil_pkg::*; #(
        parameter int NUM_COLS = 4
) (
        input  logic                      clk,
        input  logic                      rst,
        input  axil_addr_t                awaddr,
        input  logic                      awvalid,
        output logic                      awready,
        input  axil_data_t                wdata,
        input  logic                      wvalid,
        output logic                      wready,
        output axil_resp_t                bresp,
        output logic                      bvalid,
        input  logic                      bready,
        input  axil_addr_t                araddr,
        input  logic                      arvalid,
        output logic                      arready,
        output axil_data_t                rdata,
        output axil_resp_t                rresp,
        output logic                      rvalid,
        input  logic                      rready,
        output logic                      start,
        output axil_data_t [NUM_COLS-1:0] din_block,
        input  logic                      busy,
        input  logic                      done,
        input  axil_data_t [NUM_COLS-1:0] dout_block
);

        localparam int IDX_W = (NUM_COLS > 1) ? $clog2(NUM_COLS) : 1;
        localparam axil_addr_t REGION_MASK = 8'hc0;

        typedef enum logic {W_IDLE, W_RESP} wr_state_t;
        typedef enum logic {R_IDLE, R_DATA} rd_state_t;

        wr_state_t wr_state;
        rd_state_t rd_state;
        logic wr_fire;
        logic rd_fire;
        logic [3:0] wr_col;
        logic [3:0] rd_col;
        logic wr_ctrl;
        logic wr_din_ok;
        logic rd_col_ok;
        axil_data_t rd_word;
        axil_resp_t rd_code;

        assign wr_col = awaddr[5:2];
        assign rd_col = araddr[5:2];
        assign wr_ctrl = (awaddr == ADDR_CTRL);
        assign wr_din_ok = ((awaddr & REGION_MASK) == ADDR_DIN_BASE) &&
                           (awaddr[1:0] == 2'b00) && (int'(wr_col) < NUM_COLS);
        assign rd_col_ok = (araddr[1:0] == 2'b00) && (int'(rd_col) < NUM_COLS);

        // Address and data accepted together, only with no response pending
        assign wr_fire = (wr_state == W_IDLE) && awvalid && wvalid;
        assign awready = wr_fire;
        assign wready = wr_fire;
        assign bvalid = (wr_state == W_RESP);

        always_ff @(posedge clk) begin
                if (rst) begin
                        wr_state <= W_IDLE;
                        bresp <= RESP_OKAY;
                        start <= 1'b0;
                        din_block <= '0;
                end else begin
                        start <= 1'b0;
                        case (wr_state)
                        W_IDLE: begin
                                if (wr_fire) begin
                                        wr_state <= W_RESP;
                                        bresp <= (wr_ctrl || wr_din_ok) ? RESP_OKAY : RESP_SLVERR;
                                        if (wr_ctrl)
                                                start <= wdata[0];      // One-cycle pulse
                                        if (wr_din_ok)
                                                din_block[wr_col[IDX_W-1:0]] <= wdata;
                                end
                        end
                        W_RESP: begin
                                if (bready)
                                        wr_state <= W_IDLE;
                        end
                        endcase
                end
        end

        always_comb begin
                rd_word = '0;
                rd_code = RESP_SLVERR;
                if (araddr == ADDR_CTRL) begin
                        rd_code = RESP_OKAY;    // Reads as zero
                end else if (araddr == ADDR_STATUS) begin
                        rd_word = {30'b0, done, busy};
                        rd_code = RESP_OKAY;
                end else if (rd_col_ok && (araddr & REGION_MASK) == ADDR_DIN_BASE) begin
                        rd_word = din_block[rd_col[IDX_W-1:0]];
                        rd_code = RESP_OKAY;
                end else if (rd_col_ok && (araddr & REGION_MASK) == ADDR_DOUT_BASE) begin
                        rd_word = dout_block[rd_col[IDX_W-1:0]];
                        rd_code = RESP_OKAY;
                end
        end

        assign rd_fire = arvalid && arready;
        assign rvalid = (rd_state == R_DATA);

        always_ff @(posedge clk) begin
                if (rst) begin
                        rd_state <= R_IDLE;
                        arready <= 1'b0;
                end else begin
                        case (rd_state)
                        R_IDLE: begin
                                if (rd_fire) begin
                                        rd_state <= R_DATA;
                                        arready <= 1'b0;
                                end else begin
                                        arready <= 1'b1;
                                end
                        end
                        R_DATA: begin
                                if (rready) begin
                                        rd_state <= R_IDLE;
                                        arready <= 1'b1;
                                end
                        end
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (rd_fire) begin
                        rdata <= rd_word;
                        rresp <= rd_code;
                end
        end

endmodule

//--- src/inv_mix_core.sv
`timescale 1ns/1ps
/* Inverse MixColumns core
   Latches a block on start and mixes one column per cycle */
module inv_mix_core import gf_pkg::*; #(
        parameter int NUM_COLS = 4
) (
        input  logic                   clk,
        input  logic                   rst,
        input  logic                   start,
        input  column_t [NUM_COLS-1:0] din_block,
        output logic                   busy,
        output logic                   done,
        output column_t [NUM_COLS-1:0] dout_block
);

        localparam int CNT_W = (NUM_COLS > 1) ? $clog2(NUM_COLS) : 1;

        typedef enum logic {IDLE, RUN} state_t;

        state_t state;
        logic [CNT_W-1:0] col_cnt;
        logic last_col;
        column_t [NUM_COLS-1:0] store;
        column_t [NUM_COLS-1:0] store_next;
        column_t mix_in;
        column_t mix_out;

        assign busy = (state == RUN);
        assign last_col = (col_cnt == CNT_W'(NUM_COLS - 1));
        assign mix_in = store[col_cnt];

        inv_mix_column u_mix (
                .col_in(mix_in),
                .col_out(mix_out)
        );

        always_comb begin
                store_next = store;
                store_next[col_cnt] = mix_out;  // Replace selected column
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= IDLE;
                        col_cnt <= '0;
                        done <= 1'b0;
                        dout_block <= '0;
                end else begin
                        case (state)
                        IDLE: begin
                                if (start) begin
                                        state <= RUN;
                                        done <= 1'b0;
                                end
                        end
                        RUN: begin
                                col_cnt <= last_col ? '0 : col_cnt + 1'b1;
                                if (last_col) begin
                                        state <= IDLE;
                                        done <= 1'b1;
                                        dout_block <= store_next;
                                end
                        end
                        endcase
                end
        end

        // Working store, loaded once per run
        always_ff @(posedge clk) begin
                if (state == IDLE && start)
                        store <= din_block;
                else if (state == RUN)
                        store <= store_next;
        end

endmodule

//--- src/inv_mix_column.sv
`timescale 1ns/1ps
/* Inverse MixColumns on one column
   Each output row is a weighted XOR of all four input rows */
module inv_mix_column import gf_pkg::*; (
        input  column_t col_in,
        output column_t col_out
);

        byte_t row_in [4];

        for (genvar r = 0; r < 4; r++) begin : g_row
                byte_t pe;
                byte_t pb;
                byte_t pd;
                byte_t p9;

                assign row_in[r] = col_in[8*r +: 8];

                gf_mul_const #(.COEF(COEF_E)) u_mul_e (
                        .a(row_in[r]),
                        .p(pe)
                );
                gf_mul_const #(.COEF(COEF_B)) u_mul_b (
                        .a(row_in[(r + 1) % 4]),
                        .p(pb)
                );
                gf_mul_const #(.COEF(COEF_D)) u_mul_d (
                        .a(row_in[(r + 2) % 4]),
                        .p(pd)
                );
                gf_mul_const #(.COEF(COEF_9)) u_mul_9 (
                        .a(row_in[(r + 3) % 4]),
                        .p(p9)
                );

                assign col_out[8*r +: 8] = pe ^ pb ^ pd ^ p9;
        end

endmodule

//--- src/gf_mul_const.sv
`timescale 1ns/1ps
/* Constant multiplier over GF(2^8) built from repeated doubling */
module gf_mul_const import gf_pkg::*; #(
        parameter byte_t COEF = 8'h01
) (
        input  byte_t a,
        output byte_t p
);

        byte_t x2;
        byte_t x4;
        byte_t x8;

        function automatic byte_t xtime(input byte_t v);
                return {v[6:0], 1'b0} ^ (v[7] ? GF_POLY : 8'h00);
        endfunction

        assign x2 = xtime(a);
        assign x4 = xtime(x2);
        assign x8 = xtime(x4);

        // Multiples up to x8 cover every constant below 0x10
        assign p = (COEF[0] ? a  : 8'h00) ^
                   (COEF[1] ? x2 : 8'h00) ^
                   (COEF[2] ? x4 : 8'h00) ^
                   (COEF[3] ? x8 : 8'h00);

endmodule

//--- src/axil_pkg.sv
/* AXI4-Lite bus widths, response codes and register map */
package axil_pkg;

        typedef logic [7:0] axil_addr_t;        // Byte address
        typedef logic [31:0] axil_data_t;
        typedef logic [1:0] axil_resp_t;

        localparam axil_resp_t RESP_OKAY = 2'b00;
        localparam axil_resp_t RESP_SLVERR = 2'b10;

        localparam axil_addr_t ADDR_CTRL = 8'h00;       // Bit 0 starts a run
        localparam axil_addr_t ADDR_STATUS = 8'h04;     // Bit 0 busy, bit 1 done
        localparam axil_addr_t ADDR_DIN_BASE = 8'h40;   // Input column c at base + 4c
        localparam axil_addr_t ADDR_DOUT_BASE = 8'h80;  // Output column c at base + 4c

endpackage

//--- src/gf_pkg.sv
/* GF(2^8) field types and constants
   Used by the inverse MixColumns datapath */
package gf_pkg;

        typedef logic [7:0] byte_t;     // One field element
        typedef logic [31:0] column_t;  // Row 0 in bits 7:0

        // x^8 + x^4 + x^3 + x + 1 with the x^8 term dropped
        localparam byte_t GF_POLY = 8'h1b;

        localparam byte_t COEF_9 = 8'h09;
        localparam byte_t COEF_B = 8'h0b;
        localparam byte_t COEF_D = 8'h0d;
        localparam byte_t COEF_E = 8'h0e;

endpackage
